/* hw/ex_pkg.sv */
package ex_pkg;

    // issue width, the flush priority logic assumes two lanes
    localparam int NUM_LANES = 2;
    localparam int REG_ADDR_W = 5;

    // opcode as delivered by dispatch
    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_ADD  = 8'h01,
        OP_SUB  = 8'h02,
        OP_AND  = 8'h03,
        OP_OR   = 8'h04,
        OP_XOR  = 8'h05,
        OP_SLL  = 8'h06,
        OP_SRL  = 8'h07,
        OP_SRA  = 8'h08,
        OP_SLT  = 8'h09,
        OP_SLTU = 8'h0a,
        // branches and jumps
        OP_BEQ  = 8'h40,
        OP_BNE  = 8'h41,
        OP_BLT  = 8'h42,
        OP_BGE  = 8'h43,
        OP_BLTU = 8'h44,
        OP_BGEU = 8'h45,
        OP_B    = 8'h46,
        OP_BL   = 8'h47
    } alu_op_e;

    typedef enum logic [3:0] {
        FN_ADD  = 4'd0,
        FN_SUB  = 4'd1,
        FN_AND  = 4'd2,
        FN_OR   = 4'd3,
        FN_XOR  = 4'd4,
        FN_SLL  = 4'd5,
        FN_SRL  = 4'd6,
        FN_SRA  = 4'd7,
        FN_SLT  = 4'd8,
        FN_SLTU = 4'd9,
        FN_LINK = 4'd10
    } alu_func_e;

    typedef enum logic [2:0] {
        BR_NONE   = 3'd0,
        BR_EQ     = 3'd1,
        BR_NE     = 3'd2,
        BR_LT     = 3'd3,
        BR_GE     = 3'd4,
        BR_LTU    = 3'd5,
        BR_GEU    = 3'd6,
        BR_ALWAYS = 3'd7
    } br_cond_e;

endpackage

/* hw/ex_decode.sv */
`timescale 1ns/1ps

module ex_decode import ex_pkg::*; (
    input  alu_op_e   aluop_i,
    output alu_func_e func_o,
    output br_cond_e  cond_o,
    output logic      is_branch_o,
    output logic      link_o
);

    always_comb begin
        // unknown opcodes fall through as a plain add
        func_o      = FN_ADD;
        cond_o      = BR_NONE;
        is_branch_o = 1'b0;
        link_o      = 1'b0;
        case (aluop_i)
            OP_ADD:  func_o = FN_ADD;
            OP_SUB:  func_o = FN_SUB;
            OP_AND:  func_o = FN_AND;
            OP_OR:   func_o = FN_OR;
            OP_XOR:  func_o = FN_XOR;
            OP_SLL:  func_o = FN_SLL;
            OP_SRL:  func_o = FN_SRL;
            OP_SRA:  func_o = FN_SRA;
            OP_SLT:  func_o = FN_SLT;
            OP_SLTU: func_o = FN_SLTU;
            OP_BEQ: begin
                cond_o      = BR_EQ;
                is_branch_o = 1'b1;
            end
            OP_BNE: begin
                cond_o      = BR_NE;
                is_branch_o = 1'b1;
            end
            OP_BLT: begin
                cond_o      = BR_LT;
                is_branch_o = 1'b1;
            end
            OP_BGE: begin
                cond_o      = BR_GE;
                is_branch_o = 1'b1;
            end
            OP_BLTU: begin
                cond_o      = BR_LTU;
                is_branch_o = 1'b1;
            end
            OP_BGEU: begin
                cond_o      = BR_GEU;
                is_branch_o = 1'b1;
            end
            OP_B: begin
                cond_o      = BR_ALWAYS;
                is_branch_o = 1'b1;
            end
            // jump and link, result is the return address
            OP_BL: begin
                func_o      = FN_LINK;
                cond_o      = BR_ALWAYS;
                is_branch_o = 1'b1;
                link_o      = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* hw/ex_alu_lane.sv */
`timescale 1ns/1ps

module ex_alu_lane import ex_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            valid_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] src0_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] imm_i,
    input  alu_func_e       func_i,
    input  br_cond_e        cond_i,
    input  logic            is_branch_i,
    input  logic            pred_taken_i,
    input  logic [XLEN-1:0] pred_addr_i,
    output logic [XLEN-1:0] result_o,
    output logic            mispredict_o,
    output logic [XLEN-1:0] target_o
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               eq;
    logic               lt_s;
    logic               lt_u;
    logic               cond_true;
    logic               taken;
    logic [XLEN-1:0]    seq_pc;
    logic [XLEN-1:0]    jump_pc;

    assign shamt   = src1_i[SHAMT_W-1:0];
    assign eq      = (src0_i == src1_i);
    assign lt_s    = ($signed(src0_i) < $signed(src1_i));
    assign lt_u    = (src0_i < src1_i);
    assign seq_pc  = pc_i + XLEN'(4);
    assign jump_pc = pc_i + imm_i;

    always_comb begin
        case (func_i)
            FN_ADD:  result_o = src0_i + src1_i;
            FN_SUB:  result_o = src0_i - src1_i;
            FN_AND:  result_o = src0_i & src1_i;
            FN_OR:   result_o = src0_i | src1_i;
            FN_XOR:  result_o = src0_i ^ src1_i;
            FN_SLL:  result_o = src0_i << shamt;
            FN_SRL:  result_o = src0_i >> shamt;
            FN_SRA:  result_o = $signed(src0_i) >>> shamt;
            FN_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
            FN_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
            FN_LINK: result_o = seq_pc;
            default: result_o = src0_i + src1_i;
        endcase
    end

    always_comb begin
        case (cond_i)
            BR_EQ:     cond_true = eq;
            BR_NE:     cond_true = !eq;
            BR_LT:     cond_true = lt_s;
            BR_GE:     cond_true = !lt_s;
            BR_LTU:    cond_true = lt_u;
            BR_GEU:    cond_true = !lt_u;
            BR_ALWAYS: cond_true = 1'b1;
            default:   cond_true = 1'b0;
        endcase
    end

    assign taken    = is_branch_i && cond_true;
    assign target_o = taken ? jump_pc : seq_pc;

    // wrong direction, or right direction but wrong address
    assign mispredict_o = valid_i &&
                          ((taken != pred_taken_i) || (taken && (target_o != pred_addr_i)));

endmodule

/* hw/ex_commit.sv */
`timescale 1ns/1ps

module ex_commit import ex_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic                                 flush_i,
    input  logic                                 pause_i,
    input  logic [NUM_LANES-1:0]                 valid_i,
    input  logic [NUM_LANES-1:0][XLEN-1:0]       pc_i,
    input  alu_op_e [NUM_LANES-1:0]              aluop_i,
    input  logic [NUM_LANES-1:0]                 write_en_i,
    input  logic [NUM_LANES-1:0][REG_ADDR_W-1:0] write_addr_i,
    input  logic [NUM_LANES-1:0][XLEN-1:0]       result_i,
    input  logic [NUM_LANES-1:0]                 mispredict_i,
    input  logic [NUM_LANES-1:0][XLEN-1:0]       target_i,
    output logic                                 branch_flush_o,
    output logic [XLEN-1:0]                      branch_target_o,
    output logic [NUM_LANES-1:0]                 mem_valid_o,
    output logic [NUM_LANES-1:0][XLEN-1:0]       mem_pc_o,
    output alu_op_e [NUM_LANES-1:0]              mem_aluop_o,
    output logic [NUM_LANES-1:0]                 mem_write_en_o,
    output logic [NUM_LANES-1:0][REG_ADDR_W-1:0] mem_write_addr_o,
    output logic [NUM_LANES-1:0][XLEN-1:0]       mem_write_data_o
);

    // younger lane is dropped when the older one redirects
    logic [NUM_LANES-1:0] squash;

    assign squash = {mispredict_i[0], 1'b0};

    // lane 0 is older, so its target wins
    assign branch_flush_o  = (|mispredict_i) && !pause_i;
    assign branch_target_o = mispredict_i[0] ? target_i[0] : target_i[1];

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                mem_valid_o[l]      <= 1'b0;
                mem_pc_o[l]         <= '0;
                mem_aluop_o[l]      <= OP_NOP;
                mem_write_en_o[l]   <= 1'b0;
                mem_write_addr_o[l] <= '0;
                mem_write_data_o[l] <= '0;
            end
        end else if (!pause_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (squash[l]) begin
                    mem_valid_o[l]      <= 1'b0;
                    mem_pc_o[l]         <= '0;
                    mem_aluop_o[l]      <= OP_NOP;
                    mem_write_en_o[l]   <= 1'b0;
                    mem_write_addr_o[l] <= '0;
                    mem_write_data_o[l] <= '0;
                end else begin
                    mem_valid_o[l]      <= valid_i[l];
                    mem_pc_o[l]         <= pc_i[l];
                    mem_aluop_o[l]      <= aluop_i[l];
                    mem_write_en_o[l]   <= write_en_i[l];
                    mem_write_addr_o[l] <= write_addr_i[l];
                    mem_write_data_o[l] <= result_i[l];
                end
            end
        end
        // paused, register holds
    end

endmodule

/* hw/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic                                 flush_i,
    input  logic                                 pause_i,
    // from dispatch
    input  logic [NUM_LANES-1:0]                 valid_i,
    input  logic [NUM_LANES-1:0][XLEN-1:0]       pc_i,
    input  alu_op_e [NUM_LANES-1:0]              aluop_i,
    input  logic [NUM_LANES-1:0][XLEN-1:0]       src0_i,
    input  logic [NUM_LANES-1:0][XLEN-1:0]       src1_i,
    input  logic [NUM_LANES-1:0][XLEN-1:0]       imm_i,
    input  logic [NUM_LANES-1:0]                 reg_write_en_i,
    input  logic [NUM_LANES-1:0][REG_ADDR_W-1:0] reg_write_addr_i,
    input  logic [NUM_LANES-1:0]                 pred_taken_i,
    input  logic [NUM_LANES-1:0][XLEN-1:0]       pred_addr_i,
    // forwarding back to dispatch
    output logic [NUM_LANES-1:0]                 fwd_write_en_o,
    output logic [NUM_LANES-1:0][REG_ADDR_W-1:0] fwd_write_addr_o,
    output logic [NUM_LANES-1:0][XLEN-1:0]       fwd_write_data_o,
    // redirect to the pipeline controller
    output logic                                 branch_flush_o,
    output logic [XLEN-1:0]                      branch_target_o,
    // to memory stage
    output logic [NUM_LANES-1:0]                 mem_valid_o,
    output logic [NUM_LANES-1:0][XLEN-1:0]       mem_pc_o,
    output alu_op_e [NUM_LANES-1:0]              mem_aluop_o,
    output logic [NUM_LANES-1:0]                 mem_write_en_o,
    output logic [NUM_LANES-1:0][REG_ADDR_W-1:0] mem_write_addr_o,
    output logic [NUM_LANES-1:0][XLEN-1:0]       mem_write_data_o
);

    alu_func_e [NUM_LANES-1:0]           func;
    br_cond_e [NUM_LANES-1:0]            cond;
    logic [NUM_LANES-1:0]                is_branch;
    logic [NUM_LANES-1:0]                link;
    logic [NUM_LANES-1:0]                lane_we;
    logic [NUM_LANES-1:0][XLEN-1:0]      result;
    logic [NUM_LANES-1:0]                mispredict;
    logic [NUM_LANES-1:0][XLEN-1:0]      target;

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        ex_decode u_decode (
            .aluop_i     (aluop_i[l]),
            .func_o      (func[l]),
            .cond_o      (cond[l]),
            .is_branch_o (is_branch[l]),
            .link_o      (link[l])
        );

        ex_alu_lane #(.XLEN(XLEN)) u_lane (
            .valid_i      (valid_i[l]),
            .pc_i         (pc_i[l]),
            .src0_i       (src0_i[l]),
            .src1_i       (src1_i[l]),
            .imm_i        (imm_i[l]),
            .func_i       (func[l]),
            .cond_i       (cond[l]),
            .is_branch_i  (is_branch[l]),
            .pred_taken_i (pred_taken_i[l]),
            .pred_addr_i  (pred_addr_i[l]),
            .result_o     (result[l]),
            .mispredict_o (mispredict[l]),
            .target_o     (target[l])
        );

        // only linking jumps write a register among branches
        assign lane_we[l] = reg_write_en_i[l] && (!is_branch[l] || link[l]);
    end

    assign fwd_write_en_o   = lane_we;
    assign fwd_write_addr_o = reg_write_addr_i;
    assign fwd_write_data_o = result;

    ex_commit #(.XLEN(XLEN)) u_commit (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .pause_i          (pause_i),
        .valid_i          (valid_i),
        .pc_i             (pc_i),
        .aluop_i          (aluop_i),
        .write_en_i       (lane_we),
        .write_addr_i     (reg_write_addr_i),
        .result_i         (result),
        .mispredict_i     (mispredict),
        .target_i         (target),
        .branch_flush_o   (branch_flush_o),
        .branch_target_o  (branch_target_o),
        .mem_valid_o      (mem_valid_o),
        .mem_pc_o         (mem_pc_o),
        .mem_aluop_o      (mem_aluop_o),
        .mem_write_en_o   (mem_write_en_o),
        .mem_write_addr_o (mem_write_addr_o),
        .mem_write_data_o (mem_write_data_o)
    );

endmodule

/* dv/ex_tests.svh */
task automatic set_idle();
    valid_i = '0;
    pc_i = '0;
    src0_i = '0;
    src1_i = '0;
    imm_i = '0;
    reg_write_en_i = '0;
    reg_write_addr_i = '0;
    pred_taken_i = '0;
    pred_addr_i = '0;
    exp_mis = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
        aluop_i[l] = OP_NOP;
    end
endtask

// wrong flips the predicted direction
task automatic apply_lane(input int l, input alu_op_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input bit wrong);
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] res;
    logic [XLEN-1:0] tgt;
    logic            taken;
    logic            writes;
    pc = rand_word() & ~XLEN'(3);
    imm = (rand_word() & XLEN'('h3fc)) + XLEN'(8);
    ref_exec(op, pc, a, b, imm, res, taken, tgt, writes);
    valid_i[l] = 1'b1;
    pc_i[l] = pc;
    aluop_i[l] = op;
    src0_i[l] = a;
    src1_i[l] = b;
    imm_i[l] = imm;
    reg_write_en_i[l] = 1'b1;
    reg_write_addr_i[l] = REG_ADDR_W'($random(seed));
    pred_taken_i[l] = taken ^ wrong;
    pred_addr_i[l] = tgt;
    exp_res[l] = res;
    exp_tgt[l] = tgt;
    exp_we[l] = writes;
    exp_mis[l] = wrong;
endtask

task automatic check_fwd();
    string ln;
    for (int l = 0; l < NUM_LANES; l++) begin
        ln = $sformatf("[%0d]", l);
        check_word({"fwd_write_en_o", ln}, exp_we[l], fwd_write_en_o[l]);
        check_word({"fwd_write_addr_o", ln}, reg_write_addr_i[l], fwd_write_addr_o[l]);
        if (exp_we[l]) begin
            check_word({"fwd_write_data_o", ln}, exp_res[l], fwd_write_data_o[l]);
        end
    end
endtask

// older lane's target wins, pause masks the flush
task automatic check_redirect();
    logic exp_flush;
    exp_flush = (|exp_mis) && !pause_i;
    check_word("branch_flush_o", exp_flush, branch_flush_o);
    if (exp_flush) begin
        check_word("branch_target_o", exp_mis[0] ? exp_tgt[0] : exp_tgt[1], branch_target_o);
    end
endtask

task automatic check_mem_lane(input int l, input bit zero);
    string ln;
    ln = $sformatf("[%0d]", l);
    check_word({"mem_valid_o", ln}, zero ? 1'b0 : valid_i[l], mem_valid_o[l]);
    check_word({"mem_pc_o", ln}, zero ? '0 : pc_i[l], mem_pc_o[l]);
    check_op({"mem_aluop_o", ln}, zero ? OP_NOP : aluop_i[l], mem_aluop_o[l]);
    check_word({"mem_write_en_o", ln}, zero ? 1'b0 : exp_we[l], mem_write_en_o[l]);
    check_word({"mem_write_addr_o", ln}, zero ? '0 : reg_write_addr_i[l], mem_write_addr_o[l]);
    if (zero || exp_we[l]) begin
        check_word({"mem_write_data_o", ln}, zero ? '0 : exp_res[l], mem_write_data_o[l]);
    end
endtask

task automatic run_vector(input bit squash1);
    @(negedge clk);
    check_fwd();
    check_redirect();
    step();
    check_mem_lane(0, 1'b0);
    check_mem_lane(1, squash1);
endtask

task automatic alu_test();
    int err0;
    err0 = errors;
    foreach (alu_ops[i]) begin
        for (int r = 0; r < ALU_ROUNDS; r++) begin
            apply_lane(0, alu_ops[i], rand_word(), rand_word(), 1'b0);
            apply_lane(1, alu_ops[i], rand_word(), rand_word(), 1'b0);
            run_vector(1'b0);
        end
    end
    finish_test("alu results", err0);
endtask

task automatic branch_test();
    logic [XLEN-1:0] set_a[3];
    logic [XLEN-1:0] set_b[3];
    int err0;
    err0 = errors;
    // equal, signed-less, unsigned-less pairs cover both outcomes of every condition
    set_a = '{XLEN'(5), '1, XLEN'(1)};
    set_b = '{XLEN'(5), XLEN'(1), '1};
    foreach (br_ops[i]) begin
        for (int s = 0; s < 3; s++) begin
            apply_lane(0, br_ops[i], set_a[s], set_b[s], 1'b0);
            apply_lane(1, br_ops[i], set_a[(s + 1) % 3], set_b[(s + 1) % 3], 1'b0);
            run_vector(1'b0);
        end
    end
    finish_test("branch resolution", err0);
endtask

task automatic redirect_test();
    int err0;
    err0 = errors;
    apply_lane(0, OP_ADD, rand_word(), rand_word(), 1'b0);
    apply_lane(1, OP_BEQ, XLEN'(7), XLEN'(7), 1'b1);
    run_vector(1'b0);
    // both wrong, lane 1 dropped
    apply_lane(0, OP_BNE, XLEN'(1), XLEN'(2), 1'b1);
    apply_lane(1, OP_B, rand_word(), rand_word(), 1'b1);
    run_vector(1'b1);
    finish_test("mispredict redirect", err0);
endtask

task automatic pause_test();
    logic [NUM_LANES-1:0][XLEN-1:0] held_pc;
    logic [NUM_LANES-1:0][XLEN-1:0] held_data;
    logic [NUM_LANES-1:0]           held_valid;
    int err0;
    err0 = errors;
    apply_lane(0, OP_XOR, rand_word(), rand_word(), 1'b0);
    apply_lane(1, OP_OR, rand_word(), rand_word(), 1'b0);
    step();
    held_pc = mem_pc_o;
    held_data = mem_write_data_o;
    held_valid = mem_valid_o;
    pause_i = 1'b1;
    repeat (2) begin
        apply_lane(0, OP_BLT, rand_word(), rand_word(), 1'b1);
        apply_lane(1, OP_SUB, rand_word(), rand_word(), 1'b0);
        @(negedge clk);
        check_redirect();
        step();
        for (int l = 0; l < NUM_LANES; l++) begin
            check_word("mem_pc_o held", held_pc[l], mem_pc_o[l]);
            check_word("mem_write_data_o held", held_data[l], mem_write_data_o[l]);
            check_word("mem_valid_o held", held_valid[l], mem_valid_o[l]);
        end
    end
    pause_i = 1'b0;
    finish_test("pause hold", err0);
endtask

task automatic flush_reset_test();
    int err0;
    err0 = errors;
    apply_lane(0, OP_ADD, rand_word(), rand_word(), 1'b0);
    apply_lane(1, OP_SLL, rand_word(), rand_word(), 1'b0);
    flush_i = 1'b1;
    step();
    check_mem_lane(0, 1'b1);
    check_mem_lane(1, 1'b1);
    // refill the register so the next flush has something to clear
    flush_i = 1'b0;
    step();
    check_mem_lane(0, 1'b0);
    check_mem_lane(1, 1'b0);
    // flush beats pause
    flush_i = 1'b1;
    pause_i = 1'b1;
    step();
    check_mem_lane(0, 1'b1);
    check_mem_lane(1, 1'b1);
    flush_i = 1'b0;
    pause_i = 1'b0;
    // lanes stay valid through reset
    rst_n_i = 1'b0;
    repeat (4) step();
    rst_n_i = 1'b1;
    check_word("mem_valid_o after reset", '0, mem_valid_o);
    check_word("mem_write_en_o after reset", '0, mem_write_en_o);
    check_word("branch_flush_o after reset", 1'b0, branch_flush_o);
    finish_test("flush and reset", err0);
endtask

/* dv/tb_ex_stage.sv */
`timescale 1ns/1ps

module tb_ex_stage import ex_pkg::*; ();

    localparam int XLEN = 32;
    localparam int ALU_ROUNDS = 4;
    // alu vectors, three operand sets per branch op, then reset, redirect, pause, flush
    localparam int TEST_CYCLES = 10 * ALU_ROUNDS + 8 * 3 + 4 + 2 + 3 + 7;
    localparam int WATCHDOG_NS = TEST_CYCLES * 10 + 500;

    logic                                 clk = 1'b0;
    logic                                 rst_n_i;
    logic                                 flush_i;
    logic                                 pause_i;
    logic [NUM_LANES-1:0]                 valid_i;
    logic [NUM_LANES-1:0][XLEN-1:0]       pc_i;
    alu_op_e [NUM_LANES-1:0]              aluop_i;
    logic [NUM_LANES-1:0][XLEN-1:0]       src0_i;
    logic [NUM_LANES-1:0][XLEN-1:0]       src1_i;
    logic [NUM_LANES-1:0][XLEN-1:0]       imm_i;
    logic [NUM_LANES-1:0]                 reg_write_en_i;
    logic [NUM_LANES-1:0][REG_ADDR_W-1:0] reg_write_addr_i;
    logic [NUM_LANES-1:0]                 pred_taken_i;
    logic [NUM_LANES-1:0][XLEN-1:0]       pred_addr_i;
    logic [NUM_LANES-1:0]                 fwd_write_en_o;
    logic [NUM_LANES-1:0][REG_ADDR_W-1:0] fwd_write_addr_o;
    logic [NUM_LANES-1:0][XLEN-1:0]       fwd_write_data_o;
    logic                                 branch_flush_o;
    logic [XLEN-1:0]                      branch_target_o;
    logic [NUM_LANES-1:0]                 mem_valid_o;
    logic [NUM_LANES-1:0][XLEN-1:0]       mem_pc_o;
    alu_op_e [NUM_LANES-1:0]              mem_aluop_o;
    logic [NUM_LANES-1:0]                 mem_write_en_o;
    logic [NUM_LANES-1:0][REG_ADDR_W-1:0] mem_write_addr_o;
    logic [NUM_LANES-1:0][XLEN-1:0]       mem_write_data_o;

    int seed = 16591;
    int errors = 0;
    int checks = 0;

    // expected values per lane, filled by the reference model
    logic [NUM_LANES-1:0][XLEN-1:0] exp_res;
    logic [NUM_LANES-1:0][XLEN-1:0] exp_tgt;
    logic [NUM_LANES-1:0]           exp_we;
    logic [NUM_LANES-1:0]           exp_mis;

    alu_op_e alu_ops[10] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                             OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
    alu_op_e br_ops[8] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_B, OP_BL};

    ex_stage #(.XLEN(XLEN)) dut (.*);

    always #5 clk = ~clk;

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [XLEN-1:0] rand_word();
        return XLEN'({$random(seed), $random(seed)});
    endfunction

    function automatic void ref_exec(
        input  alu_op_e         op,
        input  logic [XLEN-1:0] pc,
        input  logic [XLEN-1:0] a,
        input  logic [XLEN-1:0] b,
        input  logic [XLEN-1:0] imm,
        output logic [XLEN-1:0] res,
        output logic            taken,
        output logic [XLEN-1:0] tgt,
        output logic            writes
    );
        int sh;
        sh = int'(b % XLEN);
        res = a + b;
        taken = 1'b0;
        case (op)
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLL:  res = a << sh;
            OP_SRL:  res = a >> sh;
            OP_SRA:  res = $signed(a) >>> sh;
            OP_SLT:  res = ($signed(a) < $signed(b)) ? 1 : 0;
            OP_SLTU: res = (a < b) ? 1 : 0;
            OP_BEQ:  taken = (a == b);
            OP_BNE:  taken = (a != b);
            OP_BLT:  taken = ($signed(a) < $signed(b));
            OP_BGE:  taken = ($signed(a) >= $signed(b));
            OP_BLTU: taken = (a < b);
            OP_BGEU: taken = (a >= b);
            OP_B:    taken = 1'b1;
            OP_BL: begin
                taken = 1'b1;
                res = pc + 4;
            end
            default: ;
        endcase
        writes = !(op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_B});
        tgt = taken ? pc + imm : pc + 4;
    endfunction

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected %h, got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_op(input string name, input alu_op_e exp, input alu_op_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected %h, got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        $display("test %-18s %s", name, (errors == err0) ? "ok" : "failed");
    endtask

    `include "ex_tests.svh"

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns, the test sequence did not finish", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        pause_i = 1'b0;
        set_idle();
        repeat (4) step();
        rst_n_i = 1'b1;
        alu_test();
        branch_test();
        redirect_test();
        pause_test();
        flush_reset_test();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+dv
hw/ex_pkg.sv
hw/ex_decode.sv
hw/ex_alu_lane.sv
hw/ex_commit.sv
hw/ex_stage.sv
dv/tb_ex_stage.sv
